// ==== Makefile ====
TOP := ntm_matrix_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// ==== design/ntm_matrix_multiplier.sv ====
`timescale 1ns/1ps

module ntm_matrix_multiplier (
  input  logic              CLK,
  input  logic              RST,
  input  logic              start,
  input  ntm_pkg::mat_cfg_t cfg,
  input  ntm_pkg::elem_in_t elem,
  output ntm_pkg::result_t  result,
  output logic              ready
);

  import ntm_pkg::*;

  matrix_state_e state;

  // Configuration held for the whole matrix
  mat_cfg_t cfg_q;
  size_t    row_idx;
  logic     last_row;

  // Vector multiplier side
  logic  row_start;
  data_t prod;
  logic  prod_en;
  logic  row_done;

  assign last_row = (row_idx == cfg_q.size_i - size_t'(1));

  ////////////////////////////////////////////////////////////
  // Configuration latch
  ////////////////////////////////////////////////////////////

  // Later cfg changes wait for the next start
  always_ff @(posedge CLK) begin
    if ((state == MTX_IDLE) && start) begin
      cfg_q <= cfg;
    end
  end

  ////////////////////////////////////////////////////////////
  // Row control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= MTX_IDLE;
      row_idx   <= '0;
      row_start <= 1'b0;
      result    <= '0;
      ready     <= 1'b0;
    end else begin
      // Pulses by default
      row_start       <= 1'b0;
      result.out_j_en <= 1'b0;
      result.out_i_en <= 1'b0;
      ready           <= 1'b0;
      case (state)
        MTX_IDLE: begin
          if (start) begin
            row_idx   <= '0;
            row_start <= 1'b1;
            state     <= MTX_ROW;
          end
        end
        MTX_ROW: begin
          // Forward each product one cycle later
          if (prod_en) begin
            result.data     <= prod;
            result.out_j_en <= 1'b1;
          end
          // row_done comes with the last prod_en of the row
          if (row_done) begin
            result.out_i_en <= 1'b1;
            if (last_row) begin
              // Final element of the matrix
              ready <= 1'b1;
              state <= MTX_DONE;
            end else begin
              row_idx   <= row_idx + size_t'(1);
              row_start <= 1'b1;
            end
          end
        end
        MTX_DONE: begin
          // ready is high for this one cycle
          state <= MTX_IDLE;
        end
        default: state <= MTX_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Vector multiplier
  ////////////////////////////////////////////////////////////

  ntm_vector_multiplier vector_multiplier (
    .CLK       (CLK),
    .RST       (RST),
    .row_start (row_start),
    .modulo    (cfg_q.modulo),
    .size_j    (cfg_q.size_j),
    .elem      (elem),
    .prod      (prod),
    .prod_en   (prod_en),
    .row_done  (row_done)
  );

endmodule

// ==== design/ntm_matrix_top.sv ====
`timescale 1ns/1ps

module ntm_matrix_top (
  input  logic              CLK,
  input  logic              RST,

  // Matrix control
  input  logic              start,
  input  ntm_pkg::mat_cfg_t cfg,
  output logic              ready,

  // Element stream in
  input  ntm_pkg::elem_in_t elem,

  // Products out with row and column markers
  output ntm_pkg::result_t  result
);

  ////////////////////////////////////////////////////////////
  // Matrix multiplier core
  ////////////////////////////////////////////////////////////

  // Element-wise a*b mod modulo over size_i rows of size_j
  ntm_matrix_multiplier matrix_multiplier (
    .CLK    (CLK),
    .RST    (RST),
    .start  (start),
    .cfg    (cfg),
    .elem   (elem),
    .result (result),
    .ready  (ready)
  );

endmodule

// ==== design/ntm_pkg.sv ====
package ntm_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Element and modulo width
  localparam int DATA_W = 16;
  // Row and column counts and indices
  localparam int SIZE_W = 8;

  // One matrix element or the modulo
  typedef logic [DATA_W-1:0] data_t;
  // Row or column count
  typedef logic [SIZE_W-1:0] size_t;

  ////////////////////////////////////////////////////////////
  // Stream structs
  ////////////////////////////////////////////////////////////

  // Matrix configuration sampled on start
  typedef struct packed {
    data_t modulo;
    size_t size_i;
    size_t size_j;
  } mat_cfg_t;

  // Operand strobes and values for one element pair
  typedef struct packed {
    logic  a_en;
    logic  b_en;
    data_t a;
    data_t b;
  } elem_in_t;

  // Product with column and row end markers
  typedef struct packed {
    data_t data;
    logic  out_j_en;
    logic  out_i_en;
  } result_t;

  ////////////////////////////////////////////////////////////
  // FSM states
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {MTX_IDLE, MTX_ROW, MTX_DONE} matrix_state_e;
  typedef enum logic [1:0] {VEC_IDLE, VEC_LOAD, VEC_MUL, VEC_DONE} vector_state_e;
  typedef enum logic {MUL_IDLE, MUL_RUN} mul_state_e;

endpackage

// ==== design/ntm_scalar_mod_multiplier.sv ====
`timescale 1ns/1ps

module ntm_scalar_mod_multiplier (
  input  logic           CLK,
  input  logic           RST,
  input  logic           start,
  input  ntm_pkg::data_t a,
  input  ntm_pkg::data_t b,
  input  ntm_pkg::data_t modulo,
  output ntm_pkg::data_t product,
  output logic           done
);

  import ntm_pkg::*;

  // Iteration counter covers one step per bit of b
  localparam int CNT_W = $clog2(DATA_W);

  // Two spare bits hold 2*acc + a before reduction
  typedef logic [DATA_W+1:0] wide_t;

  mul_state_e       state;
  logic [CNT_W-1:0] bit_cnt;
  logic             launch;

  // Operand and accumulator registers
  data_t a_q;
  data_t b_sh;
  data_t m_q;
  data_t acc;

  // One step of the shift and subtract
  wide_t dbl;
  wide_t red1;
  wide_t red2;
  data_t acc_next;

  assign launch = (state == MUL_IDLE) && start;

  ////////////////////////////////////////////////////////////
  // Step datapath
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Double the running remainder
    dbl = {1'b0, acc, 1'b0};
    // Add a when the current bit of b is set
    if (b_sh[DATA_W-1]) begin
      dbl = dbl + wide_t'(a_q);
    end
    // Sum stays below 3*modulo so two subtracts are enough
    red1 = (dbl >= wide_t'(m_q)) ? dbl - wide_t'(m_q) : dbl;
    red2 = (red1 >= wide_t'(m_q)) ? red1 - wide_t'(m_q) : red1;
    acc_next = red2[DATA_W-1:0];
  end

  // Operands latched on launch, b shifted out MSB first
  always_ff @(posedge CLK) begin
    if (launch) begin
      a_q  <= a;
      b_sh <= b;
      m_q  <= modulo;
      acc  <= '0;
    end else if (state == MUL_RUN) begin
      acc  <= acc_next;
      b_sh <= b_sh << 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= MUL_IDLE;
      bit_cnt <= '0;
      product <= '0;
      done    <= 1'b0;
    end else begin
      // Single cycle done
      done <= 1'b0;
      case (state)
        MUL_IDLE: begin
          if (launch) begin
            bit_cnt <= CNT_W'(DATA_W - 1);
            state   <= MUL_RUN;
          end
        end
        MUL_RUN: begin
          bit_cnt <= bit_cnt - CNT_W'(1);
          // Last bit of b
          if (bit_cnt == '0) begin
            product <= acc_next;
            done    <= 1'b1;
            state   <= MUL_IDLE;
          end
        end
        default: state <= MUL_IDLE;
      endcase
    end
  end

endmodule

// ==== design/ntm_vector_multiplier.sv ====
`timescale 1ns/1ps

module ntm_vector_multiplier (
  input  logic              CLK,
  input  logic              RST,
  input  logic              row_start,
  input  ntm_pkg::data_t    modulo,
  input  ntm_pkg::size_t    size_j,
  input  ntm_pkg::elem_in_t elem,
  output ntm_pkg::data_t    prod,
  output logic              prod_en,
  output logic              row_done
);

  import ntm_pkg::*;

  vector_state_e state;
  size_t         col;

  // Captured operands and presence flags
  data_t a_q;
  data_t b_q;
  logic  have_a;
  logic  have_b;
  logic  got_a;
  logic  got_b;

  logic  load_active;
  logic  last_col;

  // Scalar multiplier side
  logic  mul_start;
  data_t mul_product;
  logic  mul_done;

  // Strobes count in LOAD and also on the row_start cycle
  assign load_active = (state == VEC_LOAD) || ((state == VEC_IDLE) && row_start);
  assign got_a       = have_a || elem.a_en;
  assign got_b       = have_b || elem.b_en;
  assign last_col    = (col == size_j - size_t'(1));

  // First strobe of each operand wins
  always_ff @(posedge CLK) begin
    if (load_active && elem.a_en && !have_a) begin
      a_q <= elem.a;
    end
    if (load_active && elem.b_en && !have_b) begin
      b_q <= elem.b;
    end
  end

  ////////////////////////////////////////////////////////////
  // Element sequencing
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= VEC_IDLE;
      col       <= '0;
      have_a    <= 1'b0;
      have_b    <= 1'b0;
      mul_start <= 1'b0;
      prod      <= '0;
      prod_en   <= 1'b0;
      row_done  <= 1'b0;
    end else begin
      mul_start <= 1'b0;
      prod_en   <= 1'b0;
      row_done  <= 1'b0;
      case (state)
        VEC_IDLE, VEC_LOAD: begin
          // New row restarts the column index
          if ((state == VEC_IDLE) && row_start) begin
            col <= '0;
          end
          if (load_active) begin
            if (got_a && got_b) begin
              // Both operands here so launch next cycle
              mul_start <= 1'b1;
              have_a    <= 1'b0;
              have_b    <= 1'b0;
              state     <= VEC_MUL;
            end else begin
              have_a <= got_a;
              have_b <= got_b;
              state  <= VEC_LOAD;
            end
          end
        end
        VEC_MUL: begin
          // Strobes ignored while busy
          if (mul_done) begin
            prod     <= mul_product;
            prod_en  <= 1'b1;
            row_done <= last_col;
            state    <= VEC_DONE;
          end
        end
        VEC_DONE: begin
          if (last_col) begin
            state <= VEC_IDLE;
          end else begin
            col   <= col + size_t'(1);
            state <= VEC_LOAD;
          end
        end
        default: state <= VEC_IDLE;
      endcase
    end
  end

  ntm_scalar_mod_multiplier scalar_multiplier (
    .CLK     (CLK),
    .RST     (RST),
    .start   (mul_start),
    .a       (a_q),
    .b       (b_q),
    .modulo  (modulo),
    .product (mul_product),
    .done    (mul_done)
  );

endmodule

// ==== dv/ntm_matrix_asserts.sv ====
`timescale 1ns/1ps

module ntm_matrix_asserts (
  input logic                   CLK,
  input logic                   RST,
  input logic                   start,
  input ntm_pkg::matrix_state_e state,
  input ntm_pkg::result_t       result,
  input logic                   ready
);

  import ntm_pkg::*;

  ////////////////////////////////////////////////////////////
  // Output marker nesting
  ////////////////////////////////////////////////////////////

  // Matrix end is always a row end
  ready_with_row_end: assert property (
    @(posedge CLK) disable iff (RST) ready |-> result.out_i_en
  ) else $error("ready pulsed without out_i_en");

  // Row end only on a valid element
  row_end_with_elem: assert property (
    @(posedge CLK) disable iff (RST) result.out_i_en |-> result.out_j_en
  ) else $error("out_i_en high without out_j_en");

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  // Results only while a matrix runs
  no_result_in_idle: assert property (
    @(posedge CLK) disable iff (RST) result.out_j_en |-> (state != MTX_IDLE)
  ) else $error("out_j_en high while the matrix FSM is idle");

  // start always leaves IDLE
  start_leaves_idle: assert property (
    @(posedge CLK) disable iff (RST) ((state == MTX_IDLE) && start) |=> (state != MTX_IDLE)
  ) else $error("start in IDLE did not launch a matrix");

endmodule

bind ntm_matrix_multiplier ntm_matrix_asserts matrix_asserts (
  .CLK    (CLK),
  .RST    (RST),
  .start  (start),
  .state  (state),
  .result (result),
  .ready  (ready)
);

// ==== dv/ntm_matrix_checker.sv ====
`timescale 1ns/1ps

module ntm_matrix_checker (
  input logic             CLK,
  input logic             RST,
  input ntm_pkg::result_t result,
  input logic             ready
);

  import ntm_pkg::*;

  // Expected stream, one entry per element in send order
  data_t exp_data_q[$];
  logic  exp_row_q[$];
  logic  exp_mat_q[$];

  int err_count;
  int result_count;
  int ready_count;

  initial begin
    err_count    = 0;
    result_count = 0;
    ready_count  = 0;
  end

  // Called by the stimulus side when an element goes out
  task automatic push_expected(input data_t data, input logic row_end, input logic mat_end);
    exp_data_q.push_back(data);
    exp_row_q.push_back(row_end);
    exp_mat_q.push_back(mat_end);
  endtask

  ////////////////////////////////////////////////////////////
  // Per-cycle compare
  ////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    data_t exp_data;
    logic  exp_row;
    logic  exp_mat;
    if (!RST) begin
      if (ready) begin
        ready_count++;
      end
      if (result.out_j_en) begin
        if (exp_data_q.size() == 0) begin
          err_count++;
          $display("Result appeared at time %0t with no element outstanding", $time);
        end else begin
          exp_data = exp_data_q.pop_front();
          exp_row  = exp_row_q.pop_front();
          exp_mat  = exp_mat_q.pop_front();
          result_count++;
          if (result.data !== exp_data) begin
            err_count++;
            $display("FAILED at time %0t: data %h, expected %h", $time, result.data, exp_data);
          end
          if (result.out_i_en !== exp_row) begin
            err_count++;
            $display("FAILED at time %0t: out_i_en %b, expected %b",
                     $time, result.out_i_en, exp_row);
          end
          if (ready !== exp_mat) begin
            err_count++;
            $display("FAILED at time %0t: ready %b, expected %b", $time, ready, exp_mat);
          end
        end
      end else begin
        // Markers never stand alone
        if (result.out_i_en) begin
          err_count++;
          $display("Row end marker without a result at time %0t", $time);
        end
        if (ready) begin
          err_count++;
          $display("ready pulsed without a result at time %0t", $time);
        end
      end
    end
  end

  // End of run, all elements seen and one ready per matrix
  task automatic final_check(input int matrices);
    if (exp_data_q.size() != 0) begin
      err_count++;
      $display("%0d expected results never appeared", exp_data_q.size());
    end
    if (ready_count != matrices) begin
      err_count++;
      $display("FAILED at time %0t: ready pulsed %0d times, expected %0d",
               $time, ready_count, matrices);
    end
  endtask

endmodule

// ==== dv/ntm_matrix_tb.sv ====
`timescale 1ns/1ps

module ntm_matrix_tb;

  import ntm_pkg::*;

  localparam int unsigned SEED = 98170;
  localparam int NUM_MATRICES  = 20;
  localparam int CLK_PERIOD    = 4;
  localparam int RESET_CYCLES  = 10;
  // 6 by 6 at most
  localparam int MAX_ELEMS     = 36;
  localparam int TIMEOUT_NS    = NUM_MATRICES * MAX_ELEMS * (DATA_W + 10) * CLK_PERIOD + 2000;

  logic        CLK;
  logic        RST;
  logic        start;
  mat_cfg_t    cfg;
  elem_in_t    elem;
  result_t     result;
  logic        ready;
  int          timeout_errors;
  int          m;

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  ntm_matrix_top dut (
    .CLK    (CLK),
    .RST    (RST),
    .start  (start),
    .cfg    (cfg),
    .ready  (ready),
    .elem   (elem),
    .result (result)
  );

  ntm_matrix_checker chk (
    .CLK    (CLK),
    .RST    (RST),
    .result (result),
    .ready  (ready)
  );

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  // Inputs change 1 ns after the rising edge
  task automatic next_drive_slot();
    @(posedge CLK);
    #1;
  endtask

  // One strobe cycle with junk on the unstrobed fields
  task automatic pulse_operands(input logic a_en, input logic b_en,
                                input data_t a, input data_t b);
    elem.a_en = a_en;
    elem.b_en = b_en;
    elem.a    = a_en ? a : data_t'($urandom);
    elem.b    = b_en ? b : data_t'($urandom);
    next_drive_slot();
    elem.a_en = 1'b0;
    elem.b_en = 1'b0;
  endtask

  // Blocks until out_j_en is seen at a rising edge
  task automatic wait_for_result();
    @(posedge CLK);
    while (!result.out_j_en) begin
      @(posedge CLK);
    end
    #1;
  endtask

  // Random config then every element in row-major order
  task automatic run_matrix(input logic one_by_one);
    mat_cfg_t    c;
    data_t       a;
    data_t       b;
    int          sep;
    int          i;
    int          j;
    logic [63:0] full;
    c.modulo = data_t'($urandom_range(65535, 2));
    c.size_i = one_by_one ? size_t'(1) : size_t'($urandom_range(6, 1));
    c.size_j = one_by_one ? size_t'(1) : size_t'($urandom_range(6, 1));
    repeat ($urandom_range(3, 0)) next_drive_slot();
    cfg   = c;
    start = 1'b1;
    next_drive_slot();
    start = 1'b0;
    // Garbage on cfg while the latched copy holds
    cfg.modulo = data_t'($urandom);
    cfg.size_i = size_t'($urandom);
    cfg.size_j = size_t'($urandom);
    for (i = 0; i < int'(c.size_i); i++) begin
      for (j = 0; j < int'(c.size_j); j++) begin
        a    = data_t'($urandom_range(32'(c.modulo) - 32'd1, 0));
        b    = data_t'($urandom_range(32'(c.modulo) - 32'd1, 0));
        full = (64'(a) * 64'(b)) % 64'(c.modulo);
        chk.push_expected(data_t'(full), j == int'(c.size_j) - 1,
                          (j == int'(c.size_j) - 1) && (i == int'(c.size_i) - 1));
        repeat ($urandom_range(2, 0)) next_drive_slot();
        // 0 means both strobes in one cycle
        sep = $urandom_range(3, 0);
        if (sep == 0) begin
          pulse_operands(1'b1, 1'b1, a, b);
        end else begin
          if ($urandom_range(1, 0) == 1) begin
            pulse_operands(1'b1, 1'b0, a, b);
            repeat (sep - 1) next_drive_slot();
            pulse_operands(1'b0, 1'b1, a, b);
          end else begin
            pulse_operands(1'b0, 1'b1, a, b);
            repeat (sep - 1) next_drive_slot();
            pulse_operands(1'b1, 1'b0, a, b);
          end
        end
        wait_for_result();
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    timeout_errors = 0;
    RST            = 1'b1;
    start          = 1'b0;
    cfg            = '0;
    elem           = '0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1;
    RST = 1'b0;
    // Quiet stretch where any stray output gets flagged
    repeat (5) next_drive_slot();
    // First matrix is 1 by 1
    for (m = 0; m < NUM_MATRICES; m++) begin
      run_matrix(m == 0);
    end
    repeat (5) next_drive_slot();
    chk.final_check(NUM_MATRICES);
    $display("Results checked: %0d, check errors: %0d, timeouts: %0d",
             chk.result_count, chk.err_count, timeout_errors);
    if ((chk.err_count == 0) && (timeout_errors == 0)) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog sized for the worst case element count
  initial begin
    #(TIMEOUT_NS);
    timeout_errors++;
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Results checked: %0d, check errors: %0d, timeouts: %0d",
             chk.result_count, chk.err_count, timeout_errors);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== tb.f ====
design/ntm_pkg.sv
design/ntm_scalar_mod_multiplier.sv
design/ntm_vector_multiplier.sv
design/ntm_matrix_multiplier.sv
design/ntm_matrix_top.sv
dv/ntm_matrix_asserts.sv
dv/ntm_matrix_checker.sv
dv/ntm_matrix_tb.sv
